// ==== Makefile ====
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/decode_stage.sv ====
// instruction classification, immediate extraction, jal redirect
// and the decode pipeline register

`timescale 1ns/100ps

module decode_stage import fe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  f_valid,
    input  logic [xlen-1:0]       f_pc,
    input  logic [ilen-1:0]       f_instr,
    input  logic                  f_pred_taken,
    input  logic                  ex_redirect,
    output logic                  id_redirect,
    output logic [xlen-1:0]       id_target,
    output logic                  d_valid,
    output logic [xlen-1:0]       d_pc,
    output fe_op_t                d_op,
    output logic [reg_addr_w-1:0] d_rd,
    output logic [reg_addr_w-1:0] d_rs1,
    output logic [reg_addr_w-1:0] d_rs2,
    output logic [xlen-1:0]       d_imm,
    output logic                  d_pred_taken
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] j_imm;
    fe_op_t          op;
    logic [xlen-1:0] imm;

    assign opcode = f_instr[6:0];
    assign funct3 = f_instr[14:12];

    assign i_imm = {{(xlen-12){f_instr[31]}}, f_instr[31:20]};
    assign b_imm = {{(xlen-12){f_instr[31]}}, f_instr[7], f_instr[30:25],
                    f_instr[11:8], 1'b0};
    assign j_imm = {{(xlen-20){f_instr[31]}}, f_instr[19:12], f_instr[20],
                    f_instr[30:21], 1'b0};

    always_comb begin
        op  = op_nop;
        imm = i_imm;
        case (opcode)
            op_addi: begin
                if (funct3 == 3'b000) begin
                    op = op_add_imm;         // other op-imm forms are nops
                end
            end
            op_branch: begin
                imm = b_imm;
                if (funct3 == f3_beq) begin
                    op = op_beq;
                end else if (funct3 == f3_bne) begin
                    op = op_bne;
                end
            end
            op_jal: begin
                op  = op_jump;
                imm = j_imm;
            end
            default: begin
                op = op_nop;
            end
        endcase
    end

    // jal is resolved here, one bubble
    assign id_redirect = f_valid && (op == op_jump);
    assign id_target   = f_pc + j_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= f_valid && !ex_redirect;   // wrong-path instr dropped
        end
    end

    always_ff @(posedge clk) begin
        d_pc         <= f_pc;
        d_op         <= op;
        d_rd         <= f_instr[11:7];
        d_rs1        <= f_instr[19:15];
        d_rs2        <= f_instr[24:20];
        d_imm        <= imm;
        d_pred_taken <= f_pred_taken;
    end

endmodule

// ==== design/execute_stage.sv ====
// operand read with bypass, branch resolution, misprediction redirect
// and the execute result register

`timescale 1ns/100ps

module execute_stage import fe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  d_valid,
    input  logic [xlen-1:0]       d_pc,
    input  fe_op_t                d_op,
    input  logic [reg_addr_w-1:0] d_rd,
    input  logic [reg_addr_w-1:0] d_rs1,
    input  logic [reg_addr_w-1:0] d_rs2,
    input  logic [xlen-1:0]       d_imm,
    input  logic                  d_pred_taken,
    input  logic [xlen-1:0]       rf_rdata1,
    input  logic [xlen-1:0]       rf_rdata2,
    output logic [reg_addr_w-1:0] rf_raddr1,
    output logic [reg_addr_w-1:0] rf_raddr2,
    output logic                  ex_redirect,
    output logic [xlen-1:0]       ex_target,
    output logic                  x_valid,
    output logic [xlen-1:0]       x_pc,
    output logic                  x_we,
    output logic [reg_addr_w-1:0] x_rd,
    output logic [xlen-1:0]       x_value
);

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic            fwd1;
    logic            fwd2;
    logic            is_branch;
    logic            taken;
    logic [xlen-1:0] link_pc;
    logic [xlen-1:0] value;
    logic            we;

    assign rf_raddr1 = d_rs1;
    assign rf_raddr2 = d_rs2;

    // result register not yet written back to the register file
    assign fwd1 = x_valid && x_we && (x_rd != '0) && (x_rd == d_rs1);
    assign fwd2 = x_valid && x_we && (x_rd != '0) && (x_rd == d_rs2);
    assign op1  = fwd1 ? x_value : rf_rdata1;
    assign op2  = fwd2 ? x_value : rf_rdata2;

    assign link_pc   = d_pc + xlen'(4);
    assign is_branch = (d_op == op_beq) || (d_op == op_bne);

    always_comb begin
        case (d_op)
            op_beq:  taken = (op1 == op2);
            op_bne:  taken = (op1 != op2);
            default: taken = 1'b0;
        endcase
    end

    // prediction was made in fetch, correct it here
    assign ex_redirect = d_valid && is_branch && (taken != d_pred_taken);
    assign ex_target   = taken ? d_pc + d_imm : link_pc;

    always_comb begin
        case (d_op)
            op_add_imm: value = op1 + d_imm;
            op_jump:    value = link_pc;          // link address
            default:    value = '0;
        endcase
    end

    assign we = ((d_op == op_add_imm) || (d_op == op_jump)) && (d_rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        x_pc    <= d_pc;
        x_we    <= we;
        x_rd    <= d_rd;
        x_value <= value;
    end

endmodule

// ==== design/fe_pkg.sv ====
// shared widths, opcode constants and the decoded-operation type
// for the fetch/decode/execute/result pipeline

package fe_pkg;

    // datapath widths
    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes recognized by decode
    localparam logic [6:0] op_addi   = 7'b0010011;   // op-imm group, funct3 000 only
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // branch funct3 codes
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // decoded operation carried from decode to execute
    typedef enum logic [2:0] {
        op_nop     = 3'd0,   // anything unsupported retires as this
        op_add_imm = 3'd1,
        op_beq     = 3'd2,
        op_bne     = 3'd3,
        op_jump    = 3'd4    // jal, target already taken in decode
    } fe_op_t;

endpackage

// ==== design/fe_top.sv ====
// top level: pc register, fetch, decode, execute and result stages

`timescale 1ns/100ps

module fe_top import fe_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc   = 64'h8000_0000,
    parameter int              imem_words = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_hold,
    input  logic                  imem_we,
    input  logic [xlen-1:0]       imem_addr,
    input  logic [ilen-1:0]       imem_wdata,
    output logic                  retire_valid,
    output logic [xlen-1:0]       retire_pc,
    output logic                  retire_we,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_value
);

    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       next_pc;
    logic                  id_redirect;
    logic [xlen-1:0]       id_target;
    logic                  ex_redirect;
    logic [xlen-1:0]       ex_target;
    logic                  f_valid;
    logic [xlen-1:0]       f_pc;
    logic [ilen-1:0]       f_instr;
    logic                  f_pred_taken;
    logic                  d_valid;
    logic [xlen-1:0]       d_pc;
    fe_op_t                d_op;
    logic [reg_addr_w-1:0] d_rd;
    logic [reg_addr_w-1:0] d_rs1;
    logic [reg_addr_w-1:0] d_rs2;
    logic [xlen-1:0]       d_imm;
    logic                  d_pred_taken;
    logic [reg_addr_w-1:0] rf_raddr1;
    logic [reg_addr_w-1:0] rf_raddr2;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    logic                  x_valid;
    logic [xlen-1:0]       x_pc;
    logic                  x_we;
    logic [reg_addr_w-1:0] x_rd;
    logic [xlen-1:0]       x_value;

    pc_gen #(
        .reset_pc(reset_pc)
    ) pc_gen_inst (
        .clk, .rst_n, .fetch_hold, .next_pc,
        .id_redirect, .id_target, .ex_redirect, .ex_target,
        .pc
    );

    fetch_stage #(
        .reset_pc  (reset_pc),
        .imem_words(imem_words)
    ) fetch_stage_inst (
        .clk, .rst_n, .fetch_hold, .pc,
        .imem_we, .imem_addr, .imem_wdata,
        .id_redirect, .ex_redirect,
        .next_pc, .f_valid, .f_pc, .f_instr, .f_pred_taken
    );

    decode_stage decode_stage_inst (
        .clk, .rst_n, .f_valid, .f_pc, .f_instr, .f_pred_taken, .ex_redirect,
        .id_redirect, .id_target,
        .d_valid, .d_pc, .d_op, .d_rd, .d_rs1, .d_rs2, .d_imm, .d_pred_taken
    );

    execute_stage execute_stage_inst (
        .clk, .rst_n,
        .d_valid, .d_pc, .d_op, .d_rd, .d_rs1, .d_rs2, .d_imm, .d_pred_taken,
        .rf_rdata1, .rf_rdata2, .rf_raddr1, .rf_raddr2,
        .ex_redirect, .ex_target,
        .x_valid, .x_pc, .x_we, .x_rd, .x_value
    );

    result_stage result_stage_inst (
        .clk, .rst_n,
        .x_valid, .x_pc, .x_we, .x_rd, .x_value,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .retire_valid, .retire_pc, .retire_we, .retire_rd, .retire_value
    );

endmodule

// ==== design/fetch_stage.sv ====
// instruction memory with load port, backward-branch-taken predictor
// and the fetch pipeline register

`timescale 1ns/100ps

module fetch_stage import fe_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc   = 64'h8000_0000,
    parameter int              imem_words = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_hold,
    input  logic [xlen-1:0] pc,
    input  logic            imem_we,
    input  logic [xlen-1:0] imem_addr,    // byte address in the same map as pc
    input  logic [ilen-1:0] imem_wdata,
    input  logic            id_redirect,
    input  logic            ex_redirect,
    output logic [xlen-1:0] next_pc,
    output logic            f_valid,
    output logic [xlen-1:0] f_pc,
    output logic [ilen-1:0] f_instr,
    output logic            f_pred_taken
);

    localparam int         idx_w     = $clog2(imem_words);
    localparam logic [ilen-1:0] nop_instr = 32'h0000_0013;   // addi x0, x0, 0

    logic [ilen-1:0] imem [imem_words];

    logic [xlen-1:0] rd_off;
    logic [xlen-1:0] wr_off;
    logic            rd_in_range;
    logic            wr_in_range;
    logic [ilen-1:0] instr;
    logic [xlen-1:0] b_imm;
    logic            pred_taken;
    logic            flush;
    logic            f_valid_q;
    logic            drop_next;   // pc is stale after a flush under hold

    assign rd_off      = pc - reset_pc;
    assign wr_off      = imem_addr - reset_pc;
    assign rd_in_range = (rd_off >> 2) < xlen'(imem_words);
    assign wr_in_range = (wr_off >> 2) < xlen'(imem_words);

    always_ff @(posedge clk) begin
        if (imem_we && wr_in_range) begin
            imem[wr_off[idx_w+1:2]] <= imem_wdata;
        end
    end

    assign instr = rd_in_range ? imem[rd_off[idx_w+1:2]] : nop_instr;

    // beq or bne with a negative offset is predicted taken
    assign b_imm = {{(xlen-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign pred_taken = (instr[6:0] == op_branch) && instr[31] &&
                        (instr[14:12] == f3_beq || instr[14:12] == f3_bne);
    assign next_pc    = pred_taken ? pc + b_imm : pc + xlen'(4);

    assign flush = ex_redirect || id_redirect;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f_valid_q <= 1'b0;
            drop_next <= 1'b0;
        end else begin
            if (flush) begin
                f_valid_q <= 1'b0;
            end else if (!fetch_hold) begin
                f_valid_q <= !drop_next;
            end
            if (fetch_hold && flush) begin
                drop_next <= 1'b1;
            end else if (!fetch_hold) begin
                drop_next <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch_hold) begin
            f_pc         <= pc;
            f_instr      <= instr;
            f_pred_taken <= pred_taken;
        end
    end

    assign f_valid = f_valid_q && !fetch_hold;   // nothing enters decode under hold

endmodule

// ==== design/pc_gen.sv ====
// program-counter register with redirect priority, fetch hold
// and capture of a redirect that arrives during the hold

`timescale 1ns/100ps

module pc_gen import fe_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = 64'h8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_hold,
    input  logic [xlen-1:0] next_pc,      // sequential or predicted target
    input  logic            id_redirect,
    input  logic [xlen-1:0] id_target,
    input  logic            ex_redirect,
    input  logic [xlen-1:0] ex_target,
    output logic [xlen-1:0] pc
);

    logic            pend_valid;    // redirect waiting for the hold to drop
    logic [xlen-1:0] pend_target;
    logic [xlen-1:0] pc_d;

    // execute beats decode, decode beats a stored redirect
    always_comb begin
        if (ex_redirect) begin
            pc_d = ex_target;
        end else if (id_redirect) begin
            pc_d = id_target;
        end else if (pend_valid) begin
            pc_d = pend_target;
        end else begin
            pc_d = next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (!fetch_hold) begin
            pc <= pc_d;
        end
    end

    // pending flag lives only across a hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (!fetch_hold) begin
            pend_valid <= 1'b0;                 // applied this edge, or unused
        end else if (ex_redirect || id_redirect) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_hold) begin
            if (ex_redirect) begin
                pend_target <= ex_target;       // older instr, replaces any record
            end else if (id_redirect && !pend_valid) begin
                pend_target <= id_target;
            end
        end
    end

endmodule

// ==== design/result_stage.sv ====
// 32-entry register file, write-back and retire report

`timescale 1ns/100ps

module result_stage import fe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  x_valid,
    input  logic [xlen-1:0]       x_pc,
    input  logic                  x_we,
    input  logic [reg_addr_w-1:0] x_rd,
    input  logic [xlen-1:0]       x_value,
    input  logic [reg_addr_w-1:0] rf_raddr1,
    input  logic [reg_addr_w-1:0] rf_raddr2,
    output logic [xlen-1:0]       rf_rdata1,
    output logic [xlen-1:0]       rf_rdata2,
    output logic                  retire_valid,
    output logic [xlen-1:0]       retire_pc,
    output logic                  retire_we,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_value
);

    logic [xlen-1:0] regs [1:31];   // x0 is not stored

    always_ff @(posedge clk) begin
        if (rst_n && x_valid && x_we && (x_rd != '0)) begin
            regs[x_rd] <= x_value;
        end
    end

    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : regs[rf_raddr2];

    // report shows the write that commits at the end of this cycle
    assign retire_valid = x_valid;
    assign retire_pc    = x_pc;
    assign retire_we    = x_we;
    assign retire_rd    = x_rd;
    assign retire_value = x_value;

endmodule

// ==== sources.f ====
design/fe_pkg.sv
design/pc_gen.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/fe_top.sv
tests/tb_model.sv
tests/tb_top.sv

// ==== tests/tb_model.sv ====
// reference interpreter for the loaded program
// builds the expected retire stream in program order

`timescale 1ns/100ps

module tb_model import fe_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc   = 64'h8000_0000,
    parameter int              imem_words = 256,
    parameter int              max_steps  = 256
) (
    input  logic                  clk,
    input  logic                  imem_we,
    input  logic [xlen-1:0]       imem_addr,
    input  logic [ilen-1:0]       imem_wdata,
    input  logic                  build,
    input  int                    idx,
    output logic                  ready,
    output int                    count,
    output logic [xlen-1:0]       exp_pc,
    output logic                  exp_we,
    output logic [reg_addr_w-1:0] exp_rd,
    output logic [xlen-1:0]       exp_value
);

    localparam int mem_w  = $clog2(imem_words);
    localparam int step_w = $clog2(max_steps);

    logic [ilen-1:0]       mem [imem_words];
    logic [xlen-1:0]       pc_list [max_steps];
    logic                  we_list [max_steps];
    logic [reg_addr_w-1:0] rd_list [max_steps];
    logic [xlen-1:0]       value_list [max_steps];
    int                    words_loaded = 0;
    int                    n_exp = 0;
    logic                  built = 1'b0;

    assign ready     = built;
    assign count     = n_exp;
    assign exp_pc    = pc_list[idx[step_w-1:0]];
    assign exp_we    = we_list[idx[step_w-1:0]];
    assign exp_rd    = rd_list[idx[step_w-1:0]];
    assign exp_value = value_list[idx[step_w-1:0]];

    // same load bus as the DUT sees
    task automatic load_word();
        logic [xlen-1:0] word;
        word = (imem_addr - reset_pc) >> 2;
        if (word < xlen'(imem_words)) begin
            mem[word[mem_w-1:0]] = imem_wdata;
            if (int'(word) + 1 > words_loaded) begin
                words_loaded = int'(word) + 1;
            end
        end
    endtask

    // runs until the pc leaves the loaded words
    task automatic run_program();
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       next;
        logic [xlen-1:0]       regs [32];
        logic [ilen-1:0]       ins;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [xlen-1:0]       off;
        logic [reg_addr_w-1:0] rd;
        logic [step_w-1:0]     slot;
        pc = reset_pc;
        for (int r = 0; r < 32; r++) begin
            regs[r[4:0]] = '0;
        end
        while (n_exp < max_steps && (pc - reset_pc) < xlen'(4 * words_loaded)) begin
            off  = (pc - reset_pc) >> 2;
            ins  = mem[off[mem_w-1:0]];
            rd   = ins[11:7];
            src1 = regs[ins[19:15]];
            src2 = regs[ins[24:20]];
            next = pc + 64'd4;
            slot = n_exp[step_w-1:0];
            pc_list[slot]    = pc;
            we_list[slot]    = 1'b0;
            rd_list[slot]    = rd;
            value_list[slot] = '0;
            if (ins[6:0] == op_addi && ins[14:12] == 3'b000 && rd != 0) begin
                value_list[slot] = src1 + {{(xlen-12){ins[31]}}, ins[31:20]};
                we_list[slot]    = 1'b1;
                regs[rd]         = value_list[slot];
            end else if (ins[6:0] == op_branch) begin
                if ((ins[14:12] == f3_beq && src1 == src2) ||
                    (ins[14:12] == f3_bne && src1 != src2)) begin
                    next = pc + {{(xlen-12){ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end else if (ins[6:0] == op_jal) begin
                if (rd != 0) begin
                    value_list[slot] = pc + 64'd4;   // link
                    we_list[slot]    = 1'b1;
                    regs[rd]         = pc + 64'd4;
                end
                next = pc + {{(xlen-20){ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            pc = next;
            n_exp++;
        end
    endtask

    always @(posedge clk) begin
        if (imem_we) begin
            load_word();
        end
        if (build && !built) begin
            run_program();
            built = 1'b1;
        end
    end

endmodule

// ==== tests/tb_top.sv ====
// testbench: clock, reset with program load, random fetch hold,
// retire checks against the reference model, timeout and summary

`timescale 1ns/100ps

module tb_top import fe_pkg::*; ();

    localparam logic [xlen-1:0] reset_pc   = 64'h8000_0000;
    localparam int              imem_words = 256;
    localparam int              prog_len   = 15;

    logic                  clk;
    logic                  rst_n;
    logic                  fetch_hold;
    logic                  imem_we;
    logic [xlen-1:0]       imem_addr;
    logic [ilen-1:0]       imem_wdata;
    logic                  retire_valid;
    logic [xlen-1:0]       retire_pc;
    logic                  retire_we;
    logic [reg_addr_w-1:0] retire_rd;
    logic [xlen-1:0]       retire_value;

    logic                  build;
    logic                  model_ready;
    int                    exp_count;
    int                    exp_idx = 0;
    logic [xlen-1:0]       exp_pc;
    logic                  exp_we;
    logic [reg_addr_w-1:0] exp_rd;
    logic [xlen-1:0]       exp_value;

    logic [ilen-1:0] prog [16];
    integer          seed = 8922;
    int              cycle = 0;
    int              run_cycles;
    int              limit;
    int              value_errors = 0;
    int              order_errors = 0;
    int              timeout_errors = 0;

    fe_top #(
        .reset_pc  (reset_pc),
        .imem_words(imem_words)
    ) fe_top_inst (
        .clk, .rst_n, .fetch_hold, .imem_we, .imem_addr, .imem_wdata,
        .retire_valid, .retire_pc, .retire_we, .retire_rd, .retire_value
    );

    tb_model #(
        .reset_pc  (reset_pc),
        .imem_words(imem_words)
    ) tb_model_inst (
        .clk, .imem_we, .imem_addr, .imem_wdata, .build,
        .idx(exp_idx), .ready(model_ready), .count(exp_count),
        .exp_pc, .exp_we, .exp_rd, .exp_value
    );

    function automatic logic [ilen-1:0] addi_word(input int rd, input int rs1, input int imm);
        logic [11:0] i;
        i = imm[11:0];
        return {i, 5'(rs1), 3'b000, 5'(rd), op_addi};
    endfunction

    function automatic logic [ilen-1:0] branch_word(input logic [2:0] f3, input int rs1,
                                                    input int rs2, input int imm);
        logic [12:0] b;
        b = imm[12:0];
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], op_branch};
    endfunction

    function automatic logic [ilen-1:0] jal_word(input int rd, input int imm);
        logic [20:0] j;
        j = imm[20:0];
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), op_jal};
    endfunction

    task automatic fill_program();
        prog[0]  = addi_word(1, 0, 5);                // dependent chain
        prog[1]  = addi_word(2, 1, 3);
        prog[2]  = addi_word(3, 2, -1);
        prog[3]  = branch_word(f3_beq, 3, 3, 8);      // forward, taken
        prog[4]  = addi_word(4, 0, 99);               // skipped
        prog[5]  = branch_word(f3_bne, 1, 1, 8);      // forward, not taken
        prog[6]  = addi_word(5, 0, 5);                // loop count
        prog[7]  = addi_word(6, 5, 10);
        prog[8]  = addi_word(5, 5, -1);
        prog[9]  = branch_word(f3_bne, 5, 0, -8);     // backward, exits after five passes
        prog[10] = jal_word(7, 8);
        prog[11] = addi_word(8, 0, 1);                // jumped over
        prog[12] = addi_word(0, 1, 7);                // write to x0 dropped
        prog[13] = addi_word(9, 0, 1);
        prog[14] = addi_word(10, 9, 1);
    endtask

    task automatic check_retire();
        if (exp_idx == 0) begin
            assert (retire_pc == reset_pc) else begin
                $display("CHECK FAILED at %0t: first retire pc %h, not the reset pc",
                         $time, retire_pc);
                value_errors++;
            end
        end
        assert (retire_pc == exp_pc) else begin
            $display("CHECK FAILED at %0t: retire %0d pc %h, expected %h",
                     $time, exp_idx, retire_pc, exp_pc);
            value_errors++;
        end
        assert (retire_we == exp_we) else begin
            $display("CHECK FAILED at %0t: retire %0d at pc %h has we %0b, expected %0b",
                     $time, exp_idx, retire_pc, retire_we, exp_we);
            value_errors++;
        end
        if (exp_we) begin
            assert (retire_rd == exp_rd && retire_value == exp_value) else begin
                $display("CHECK FAILED at %0t: retire %0d wrote x%0d = %h, expected x%0d = %h",
                         $time, exp_idx, retire_rd, retire_value, exp_rd, exp_value);
                value_errors++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // program goes in while reset holds the pipeline
    initial begin
        rst_n      = 1'b0;
        fetch_hold = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        build      = 1'b0;
        fill_program();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i < prog_len) begin
                imem_we    <= 1'b1;
                imem_addr  <= reset_pc + xlen'(4 * i);
                imem_wdata <= prog[i[3:0]];
            end else begin
                imem_we <= 1'b0;
            end
        end
        rst_n <= 1'b1;
        build <= 1'b1;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            fetch_hold <= ($random(seed) & 3) == 0;   // about one cycle in four
        end
    end

    // retire monitor, samples before the edge updates
    always @(posedge clk) begin
        cycle++;
        if (!rst_n) begin
            if (cycle > 2) begin
                assert (!retire_valid) else begin
                    $display("retire_valid went high during reset at %0t", $time);
                    order_errors++;
                end
            end
        end else if (retire_valid && !model_ready) begin
            $display("an instruction retired at %0t before the expected stream existed", $time);
            order_errors++;
        end else if (retire_valid && exp_idx < exp_count) begin
            check_retire();
            exp_idx++;
        end
    end

    initial begin
        wait (model_ready);
        limit      = 8 * exp_count + 100;
        run_cycles = 0;
        while (exp_idx < exp_count && run_cycles < limit) begin
            @(negedge clk);
            run_cycles++;
        end
        if (exp_count == 0) begin
            $display("the reference model produced no expected retirements");
            order_errors++;
        end
        if (exp_idx < exp_count) begin
            $display("timeout after %0d cycles with %0d retirements still missing",
                     run_cycles, exp_count - exp_idx);
            timeout_errors++;
        end
        $display("errors: value %0d, order %0d, timeout %0d",
                 value_errors, order_errors, timeout_errors);
        if (value_errors + order_errors + timeout_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
